// ==== Makefile ====
# Verilator flow for the UART project

VERILATOR  ?= verilator
TOP        := tb_uart_top
FILELIST   := compile.f
OBJ_DIR    := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert
RUN_ARGS   := +verilator+error+limit+1000

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "=== PASS ===" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== common/uart_consts.svh ====
`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

// frame geometry
`define UART_DATA_W        8                  // data bits per frame
`define UART_FRAME_BITS    (`UART_DATA_W + 3) // start + data + parity + stop

// bit timing, counted in tx_clk cycles
`define UART_CLKS_PER_BIT  8                  // clocks per serial bit

// receive side
`define UART_SYNC_STAGES   3                  // flops in front of the rx fsm

// parity select
`define UART_PARITY_ODD    1'b0               // 0 even, 1 odd

`endif

// ==== common/uart_pkg.sv ====
`default_nettype none

`include "uart_consts.svh"

package uart_pkg;

	// one frame seen as a shift word or as its fields
	typedef union packed {
		logic [`UART_FRAME_BITS-1:0] raw;   // bit 0 goes out first
		struct packed {
			logic                    stop;   // always 1
			logic                    parity; // per UART_PARITY_ODD
			logic [`UART_DATA_W-1:0] data;   // lsb sent first
			logic                    start;  // always 0
		} fields;
	} uart_frame_u;

	// receiver position in the frame
	typedef enum logic [3:0] {
		RX_IDLE   = 4'd0, // waiting for a low line
		RX_START  = 4'd1, // checking the start bit
		RX_DATA   = 4'd2, // data bits
		RX_PARITY = 4'd3, // parity bit
		RX_STOP   = 4'd4  // stop bit
	} rx_state_e;

	// one mid-bit sample and its role in the frame
	typedef struct packed {
		logic strobe;    // a bit was sampled this cycle
		logic level;     // synchronized line value
		logic is_data;   // sample is a data bit
		logic is_parity; // sample is the parity bit
		logic is_stop;   // sample is the stop bit
	} rx_sample_s;

endpackage

`default_nettype wire

// ==== compile.f ====
+incdir+common
common/uart_pkg.sv
design/baud_timer.sv
transmitter/uart_tx.sv
receiver/rx_fsm.sv
receiver/rx_deserializer.sv
design/uart_top.sv
testbench/uart_checker.sv
testbench/tb_uart_top.sv

// ==== design/baud_timer.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "uart_consts.svh"

module baud_timer (
	input  wire  tx_clk,
	input  wire  reset_tx,
	input  wire  i_run,      // count only while high
	output logic o_mid_tick, // middle of the bit period
	output logic o_end_tick  // last cycle of the bit period
);

	localparam int CNT_W = $clog2(`UART_CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] MID_CNT = CNT_W'(`UART_CLKS_PER_BIT / 2 - 1); // fourth cycle
	localparam logic [CNT_W-1:0] END_CNT = CNT_W'(`UART_CLKS_PER_BIT - 1);

	logic [CNT_W-1:0] cnt_q; // cycle within the current bit

	always_ff @(posedge tx_clk) begin
		if (reset_tx || !i_run) begin
			cnt_q <= '0;            // idle timer sits at the bit start
		end else if (cnt_q == END_CNT) begin
			cnt_q <= '0;            // wrap into the next bit
		end else begin
			cnt_q <= cnt_q + 1'b1;
		end
	end

	assign o_mid_tick = i_run && (cnt_q == MID_CNT);
	assign o_end_tick = i_run && (cnt_q == END_CNT);

endmodule

`default_nettype wire

// ==== design/uart_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "uart_consts.svh"

module uart_top (
	input  wire                     tx_clk,
	input  wire                     reset_tx,
	input  wire                     i_tx_enable,  // send request
	input  wire  [`UART_DATA_W-1:0] i_tx_data,
	input  wire                     i_serial_in,  // receive line
	output logic                    o_serial_out, // transmit line
	output logic                    o_tx_busy,
	output logic [`UART_DATA_W-1:0] o_rx_data,
	output logic                    o_rx_valid,
	output logic                    o_rx_error
);

	import uart_pkg::*;

	logic       tx_run;     // tx timer enable
	logic       tx_bit_end; // tx bit boundary
	logic       rx_run;     // rx timer enable
	logic       rx_mid;     // rx sample point
	rx_sample_s rx_sample;

	baud_timer u_tx_timer (
		.tx_clk     (tx_clk),
		.reset_tx   (reset_tx),
		.i_run      (tx_run),
		.o_mid_tick (),           // transmitter works on bit ends only
		.o_end_tick (tx_bit_end)
	);

	uart_tx u_tx (
		.tx_clk       (tx_clk),
		.reset_tx     (reset_tx),
		.i_tx_enable  (i_tx_enable),
		.i_tx_data    (i_tx_data),
		.i_bit_end    (tx_bit_end),
		.o_run        (tx_run),
		.o_serial_out (o_serial_out),
		.o_tx_busy    (o_tx_busy)
	);

	baud_timer u_rx_timer (
		.tx_clk     (tx_clk),
		.reset_tx   (reset_tx),
		.i_run      (rx_run),
		.o_mid_tick (rx_mid),
		.o_end_tick ()            // receiver samples at mid-bit only
	);

	rx_fsm u_rx_fsm (
		.tx_clk      (tx_clk),
		.reset_tx    (reset_tx),
		.i_serial_in (i_serial_in),
		.i_mid_tick  (rx_mid),
		.o_run       (rx_run),
		.o_sample    (rx_sample)
	);

	rx_deserializer u_rx_deser (
		.tx_clk     (tx_clk),
		.reset_tx   (reset_tx),
		.i_sample   (rx_sample),
		.o_rx_data  (o_rx_data),
		.o_rx_valid (o_rx_valid),
		.o_rx_error (o_rx_error)
	);

endmodule

`default_nettype wire

// ==== receiver/rx_deserializer.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "uart_consts.svh"

module rx_deserializer (
	input  wire                     tx_clk,
	input  wire                     reset_tx,
	input  wire uart_pkg::rx_sample_s i_sample,   // samples from the rx fsm
	output logic [`UART_DATA_W-1:0] o_rx_data,  // last complete byte
	output logic                    o_rx_valid, // one cycle at the stop bit
	output logic                    o_rx_error  // parity mismatch qualified by valid
);

	logic [`UART_DATA_W-1:0] shift_q;     // data bits with the lsb arriving first
	logic                    par_q;       // running parity over data and parity bit
	logic                    frame_start; // start bit sample
	logic                    frame_end;   // stop bit sample

	assign frame_start = i_sample.strobe &&
		!(i_sample.is_data || i_sample.is_parity || i_sample.is_stop);
	assign frame_end   = i_sample.strobe && i_sample.is_stop;

	always_ff @(posedge tx_clk) begin
		if (i_sample.strobe && i_sample.is_data) begin
			shift_q <= {i_sample.level, shift_q[`UART_DATA_W-1:1]};
		end
		if (frame_end) begin
			o_rx_data <= shift_q; // held until the next stop bit
		end
	end

	always_ff @(posedge tx_clk) begin
		if (reset_tx) begin
			par_q      <= 1'b0;
			o_rx_valid <= 1'b0;
			o_rx_error <= 1'b0;
		end else begin
			if (frame_start) begin
				par_q <= `UART_PARITY_ODD; // odd parity starts from 1
			end else if (i_sample.strobe && (i_sample.is_data || i_sample.is_parity)) begin
				par_q <= par_q ^ i_sample.level;
			end
			o_rx_valid <= frame_end;
			o_rx_error <= frame_end && par_q; // nonzero means parity bit disagrees
		end
	end

endmodule

`default_nettype wire

// ==== receiver/rx_fsm.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "uart_consts.svh"

module rx_fsm (
	input  wire                 tx_clk,
	input  wire                 reset_tx,
	input  wire                 i_serial_in, // raw serial line
	input  wire                 i_mid_tick,  // mid-bit tick from the baud timer
	output logic                o_run,       // baud timer runs while a frame is in
	output uart_pkg::rx_sample_s o_sample    // sampled bit and its role
);

	import uart_pkg::*;

	localparam int DCNT_W = $clog2(`UART_DATA_W);
	localparam logic [DCNT_W-1:0] LAST_DATA = DCNT_W'(`UART_DATA_W - 1);

	logic [`UART_SYNC_STAGES-1:0] sync_q;     // synchronizer chain with [0] at the pin
	logic                         line;       // synchronized line
	rx_state_e                    state_q;
	logic [DCNT_W-1:0]            data_cnt_q; // data bit being sampled
	logic                         false_start;

	assign line = sync_q[`UART_SYNC_STAGES-1];

	always_ff @(posedge tx_clk) begin
		if (reset_tx) begin
			sync_q <= '1; // idle line level
		end else begin
			sync_q <= {sync_q[`UART_SYNC_STAGES-2:0], i_serial_in};
		end
	end

	always_ff @(posedge tx_clk) begin
		if (reset_tx) begin
			state_q    <= RX_IDLE;
			data_cnt_q <= '0;
		end else begin
			case (state_q)
				RX_IDLE: begin
					if (!line) state_q <= RX_START; // start edge
				end
				RX_START: begin
					if (i_mid_tick) begin
						state_q    <= line ? RX_IDLE : RX_DATA; // high again means a glitch
						data_cnt_q <= '0;
					end
				end
				RX_DATA: begin
					if (i_mid_tick) begin
						if (data_cnt_q == LAST_DATA) state_q <= RX_PARITY;
						data_cnt_q <= data_cnt_q + 1'b1;
					end
				end
				RX_PARITY: begin
					if (i_mid_tick) state_q <= RX_STOP;
				end
				RX_STOP: begin
					if (i_mid_tick) state_q <= RX_IDLE; // back to idle in mid stop bit
				end
				default: state_q <= RX_IDLE;
			endcase
		end
	end

	assign false_start = (state_q == RX_START) && line;
	assign o_run       = (state_q != RX_IDLE);

	// start bit strobes with no role flag set
	always_comb begin
		o_sample.strobe    = i_mid_tick && !false_start;
		o_sample.level     = line;
		o_sample.is_data   = (state_q == RX_DATA);
		o_sample.is_parity = (state_q == RX_PARITY);
		o_sample.is_stop   = (state_q == RX_STOP);
	end

endmodule

`default_nettype wire

// ==== testbench/tb_uart_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "uart_consts.svh"

module tb_uart_top;

	import uart_pkg::*;

	localparam int CLK_HALF     = 20;   // 40 ns period
	localparam int RESET_CYCLES = 10;
	localparam int VALID_WAIT   = 100;  // accept to valid bound
	localparam int MAX_CYCLES   = 6000; // 40 frames of at most 110 cycles plus margin
	localparam int NUM_TESTS    = 5;

	logic                    tx_clk;
	logic                    reset_tx;
	logic                    i_tx_enable;
	logic [`UART_DATA_W-1:0] i_tx_data;
	logic                    flip_q;       // inverts the loopback line
	wire                     serial_loop;  // o_serial_out back into the receiver
	logic                    o_serial_out;
	logic                    o_tx_busy;
	logic [`UART_DATA_W-1:0] o_rx_data;
	logic                    o_rx_valid;
	logic                    o_rx_error;

	int          err_cnt;
	int          cycle_cnt;    // tx_clk edges since time zero
	int          tests_failed;
	int          test_base;    // error total when the current test began
	logic [31:0] rng_state;

	assign serial_loop = o_serial_out ^ flip_q;

	uart_top u_uart_top (
		.tx_clk       (tx_clk),
		.reset_tx     (reset_tx),
		.i_tx_enable  (i_tx_enable),
		.i_tx_data    (i_tx_data),
		.i_serial_in  (serial_loop),
		.o_serial_out (o_serial_out),
		.o_tx_busy    (o_tx_busy),
		.o_rx_data    (o_rx_data),
		.o_rx_valid   (o_rx_valid),
		.o_rx_error   (o_rx_error)
	);

	initial begin
		tx_clk = 1'b0;
		forever #CLK_HALF tx_clk = ~tx_clk;
	end

	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < MAX_CYCLES) begin
			@(posedge tx_clk);
			cycle_cnt++;
		end
		$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
		$display("=== FAIL ===");
		$finish;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	task automatic note_mismatch(input string msg);
		$display("Mismatch at %0t: %s", $time, msg);
		err_cnt++;
	endtask

	task automatic check_idle_outputs();
		assert (o_serial_out === 1'b1) else note_mismatch("line not high in idle");
		assert (o_tx_busy === 1'b0) else note_mismatch("busy set in idle");
		assert (o_rx_valid === 1'b0) else note_mismatch("valid set in idle");
		assert (o_rx_error === 1'b0) else note_mismatch("error set in idle");
	endtask

	// one frame through the loopback with flip_bit < 0 leaving the line intact
	task automatic send_frame(input logic [`UART_DATA_W-1:0] data, input int flip_bit,
		input bit poke_busy);
		uart_frame_u             exp_frame;
		logic [`UART_DATA_W-1:0] exp_data;
		logic                    exp_err;
		int                      t0;
		int                      b;
		int                      k;
		int                      ones;
		bit                      got_valid;
		ones = 0;
		for (k = 0; k < `UART_DATA_W; k++) begin
			ones += data[k];
		end
		exp_frame.fields.start = 1'b0;
		exp_frame.fields.data  = data;
		if (`UART_PARITY_ODD) begin
			exp_frame.fields.parity = (ones % 2 == 0); // ones count made odd
		end else begin
			exp_frame.fields.parity = (ones % 2 == 1); // ones count made even
		end
		exp_frame.fields.stop  = 1'b1;
		exp_data = data;
		exp_err  = 1'b0;
		if (flip_bit >= 0) begin
			exp_data = data ^ (`UART_DATA_W'(1) << flip_bit);
			exp_err  = 1'b1;
		end
		@(posedge tx_clk);
		i_tx_enable <= 1'b1;
		i_tx_data   <= data;
		@(posedge tx_clk); // accepted on this edge
		i_tx_enable <= 1'b0;
		@(negedge tx_clk);
		t0 = cycle_cnt;
		assert (o_tx_busy === 1'b0) else note_mismatch("busy rose on the accept edge");
		@(negedge tx_clk);
		assert (o_tx_busy === 1'b1) else note_mismatch("busy not set one cycle after enable");
		for (b = 0; b < `UART_FRAME_BITS; b++) begin
			@(posedge tx_clk);
			flip_q <= (flip_bit >= 0) && (b == flip_bit + 1); // frame bit 0 is the start bit
			if (poke_busy && b == 3) begin
				i_tx_enable <= 1'b1;  // must be ignored while busy
				i_tx_data   <= ~data;
			end
			@(posedge tx_clk);
			i_tx_enable <= 1'b0;
			repeat (3) @(negedge tx_clk); // mid-bit
			assert (o_serial_out === exp_frame.raw[b])
				else note_mismatch($sformatf("frame bit %0d of 0x%02h is %b, expected %b",
					b, data, o_serial_out, exp_frame.raw[b]));
			if (b < `UART_FRAME_BITS - 1) repeat (4) @(negedge tx_clk);
		end
		got_valid = 1'b0;
		while (!got_valid && (cycle_cnt - t0) <= VALID_WAIT) begin
			@(negedge tx_clk);
			got_valid = o_rx_valid;
		end
		if (!got_valid) begin
			$display("Error at %0t: no receive valid within %0d cycles of the frame start",
				$time, VALID_WAIT);
			err_cnt++;
		end else begin
			assert (o_rx_data === exp_data)
				else note_mismatch($sformatf("received 0x%02h, expected 0x%02h",
					o_rx_data, exp_data));
			assert (o_rx_error === exp_err)
				else note_mismatch($sformatf("error flag %b, expected %b", o_rx_error, exp_err));
		end
	endtask

	task automatic close_test(input int num, input string name);
		int now_fails;
		now_fails = err_cnt + u_uart_top.u_checker.fail_cnt;
		if (now_fails != test_base) tests_failed++;
		$display("test %0d %s: %s, %0d errors", num, name,
			(now_fails == test_base) ? "ok" : "failed", now_fails - test_base);
		test_base = now_fails;
	endtask

	initial begin
		int i;
		int total_fails;
		reset_tx     <= 1'b1;
		i_tx_enable  <= 1'b0;
		i_tx_data    <= '0;
		flip_q       <= 1'b0;
		err_cnt      = 0;
		tests_failed = 0;
		test_base    = 0;
		rng_state    = 32'd94;
		for (i = 0; i < RESET_CYCLES; i++) begin
			@(posedge tx_clk);
			if (i == RESET_CYCLES - 1) reset_tx <= 1'b0;
			@(negedge tx_clk);
			check_idle_outputs();
		end
		repeat (4) begin
			@(negedge tx_clk);
			check_idle_outputs();
		end
		close_test(1, "reset state");
		for (i = 0; i < 4; i++) begin
			rng_state = xorshift32(rng_state);
			send_frame(rng_state[`UART_DATA_W-1:0], -1, 1'b0);
		end
		close_test(2, "frame shape");
		for (i = 0; i < 3; i++) begin
			rng_state = xorshift32(rng_state);
			send_frame(rng_state[`UART_DATA_W-1:0], -1, 1'b1); // extra enable mid-frame
		end
		close_test(3, "busy timing");
		for (i = 0; i < 30; i++) begin
			rng_state = xorshift32(rng_state);
			send_frame(rng_state[`UART_DATA_W-1:0], -1, 1'b0);
		end
		close_test(4, "loopback data");
		for (i = 0; i < 3; i++) begin
			rng_state = xorshift32(rng_state);
			send_frame(rng_state[`UART_DATA_W-1:0], 3 * i + 1, 1'b0); // data bits 1, 4, 7
		end
		close_test(5, "parity error");
		total_fails = err_cnt + u_uart_top.u_checker.fail_cnt;
		$display("summary: %0d tests, %0d failed, %0d errors", NUM_TESTS, tests_failed,
			total_fails);
		if (total_fails == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== testbench/uart_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "uart_consts.svh"

module uart_checker (
	input wire tx_clk,
	input wire reset_tx,
	input wire i_serial_line, // transmit line of the DUT
	input wire i_tx_busy,
	input wire i_rx_valid,
	input wire i_rx_error
);

	localparam int BUSY_CYCLES = `UART_FRAME_BITS * `UART_CLKS_PER_BIT; // 88 for 11 bits

	int fail_cnt = 0; // failed assertions so far
	int busy_run_q;   // samples of busy high in a row

	always_ff @(posedge tx_clk) begin
		if (reset_tx || !i_tx_busy) begin
			busy_run_q <= 0;
		end else begin
			busy_run_q <= busy_run_q + 1;
		end
	end

	a_reset_idle: assert property (@(posedge tx_clk)
		reset_tx |=> (i_serial_line && !i_tx_busy && !i_rx_valid && !i_rx_error))
		else begin $error("outputs not idle after reset"); fail_cnt++; end

	a_idle_line_high: assert property (@(posedge tx_clk) disable iff (reset_tx)
		!i_tx_busy |-> i_serial_line)
		else begin $error("line low while transmitter idle"); fail_cnt++; end

	a_busy_length: assert property (@(posedge tx_clk) disable iff (reset_tx)
		$fell(i_tx_busy) |-> (busy_run_q == BUSY_CYCLES))
		else begin $error("busy dropped before the frame ended"); fail_cnt++; end

	a_busy_bound: assert property (@(posedge tx_clk) disable iff (reset_tx)
		i_tx_busy |-> (busy_run_q < BUSY_CYCLES))
		else begin $error("busy held past one frame"); fail_cnt++; end

	a_valid_pulse: assert property (@(posedge tx_clk) disable iff (reset_tx)
		i_rx_valid |=> !i_rx_valid)
		else begin $error("valid longer than one cycle"); fail_cnt++; end

endmodule

bind uart_top uart_checker u_checker (
	.tx_clk        (tx_clk),
	.reset_tx      (reset_tx),
	.i_serial_line (o_serial_out),
	.i_tx_busy     (o_tx_busy),
	.i_rx_valid    (o_rx_valid),
	.i_rx_error    (o_rx_error)
);

`default_nettype wire

// ==== transmitter/uart_tx.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "uart_consts.svh"

module uart_tx (
	input  wire                    tx_clk,
	input  wire                    reset_tx,
	input  wire                    i_tx_enable,  // one-cycle request
	input  wire [`UART_DATA_W-1:0] i_tx_data,    // byte to send
	input  wire                    i_bit_end,    // end tick from the baud timer
	output logic                   o_run,        // keeps the baud timer counting
	output logic                   o_serial_out, // serial line held high when idle
	output logic                   o_tx_busy     // frame on the line
);

	import uart_pkg::*;

	localparam int BCNT_W = $clog2(`UART_FRAME_BITS);
	localparam logic [BCNT_W-1:0] LAST_BIT = BCNT_W'(`UART_FRAME_BITS - 1);

	uart_frame_u       frame_d;   // frame built from the input byte
	uart_frame_u       shift_q;   // bits still to go out
	logic [BCNT_W-1:0] bit_cnt_q; // bit now on the line
	logic              load_q;    // frame latched, start bit goes out next
	logic              busy_q;
	logic              serial_q;
	logic              accept;
	logic              shift;

	assign accept = i_tx_enable && !busy_q && !load_q; // requests while busy are dropped
	assign shift  = load_q || (busy_q && i_bit_end);

	always_comb begin
		frame_d.fields.start  = 1'b0;
		frame_d.fields.data   = i_tx_data;
		frame_d.fields.parity = (^i_tx_data) ^ `UART_PARITY_ODD; // odd flips the even parity
		frame_d.fields.stop   = 1'b1;
	end

	// byte latch and shift register
	always_ff @(posedge tx_clk) begin
		if (accept) begin
			shift_q <= frame_d;
		end else if (shift) begin
			shift_q.raw <= {1'b1, shift_q.raw[`UART_FRAME_BITS-1:1]}; // fill with idle level
		end
	end

	always_ff @(posedge tx_clk) begin
		if (reset_tx) begin
			load_q    <= 1'b0;
			busy_q    <= 1'b0;
			serial_q  <= 1'b1;
			bit_cnt_q <= '0;
		end else if (load_q) begin
			load_q    <= 1'b0;
			busy_q    <= 1'b1;
			serial_q  <= shift_q.raw[0]; // start bit
			bit_cnt_q <= '0;
		end else if (busy_q && i_bit_end) begin
			if (bit_cnt_q == LAST_BIT) begin
				busy_q   <= 1'b0;     // stop bit done
				serial_q <= 1'b1;
			end else begin
				serial_q  <= shift_q.raw[0];
				bit_cnt_q <= bit_cnt_q + 1'b1;
			end
		end else if (accept) begin
			load_q <= 1'b1;
		end
	end

	assign o_run        = busy_q;
	assign o_serial_out = serial_q;
	assign o_tx_busy    = busy_q;

endmodule

`default_nettype wire
